// File: Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_eeprom_host
FILELIST   := eeprom_host.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CMD    = 5'h00; // [0] go, [1] read not write
    localparam apb_addr_t REG_ADDR   = 5'h04;
    localparam apb_addr_t REG_WDATA  = 5'h08;
    localparam apb_addr_t REG_STATUS = 5'h0C; // read only
    localparam apb_addr_t REG_RDATA  = 5'h10; // read only

    localparam int CMD_GO_BIT  = 0;
    localparam int CMD_RNW_BIT = 1;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_NACK_BIT = 1;

endpackage : apb_regs_pkg

`default_nettype wire

// File: common/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // 2048-byte array, block bits in [10:8]
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] byte_t;

    // bit engine commands
    typedef enum logic [1:0]
    {
        START,
        STOP,
        WRITE_BYTE,
        READ_BYTE
    } bit_cmd_t;

    // fixed upper nibble of the device select byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

endpackage : i2c_pkg

`default_nettype wire

// File: dv/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
    import i2c_pkg::*;
(
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic scl,
    input  wire logic sda,         // resolved bus level
    input  wire logic nack_en,     // refuse the device select byte
    output logic      sda_oe,      // high pulls SDA low
    output int        write_count
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_DEV,
        M_ADDR,
        M_WRITE,
        M_READ
    } model_state_t;

    model_state_t state;
    model_state_t next_state;      // taken after the ack bit
    byte_t        mem [0:2047];
    byte_t        shreg;
    logic [3:0]   bit_cnt;         // scl rises seen in this byte
    ee_addr_t     ptr;
    logic         scl_q;
    logic         sda_q;
    logic         scl_rise;
    logic         scl_fall;
    logic         start_cond;
    logic         stop_cond;

    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= M_IDLE;
            next_state  <= M_IDLE;
            bit_cnt     <= '0;
            sda_oe      <= 1'b0;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            ptr         <= '0;
            shreg       <= '0;
            write_count <= 0;
            for (int i = 0; i < 2048; i++)
                mem[i] <= byte_t'(i ^ (i >> 8) ^ 32'h5c);
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_cond)
            begin
                state   <= M_DEV;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end
            else if (stop_cond)
            begin
                state   <= M_IDLE;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end
            else if (state != M_IDLE && scl_rise)
            begin
                if (state != M_READ && bit_cnt < 4'd8)
                    shreg <= {shreg[6:0], sda};
                if (state == M_READ && bit_cnt == 4'd8 && sda)
                    next_state <= M_IDLE; // master nack ends the read
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (state != M_IDLE && scl_fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    sda_oe <= 1'b0;
                    case (state)
                        M_DEV:
                        begin
                            if (shreg[7:4] == DEV_CODE && !nack_en)
                            begin
                                sda_oe     <= 1'b1;
                                ptr[10:8]  <= shreg[3:1];
                                next_state <= shreg[0] ? M_READ : M_ADDR;
                            end
                            else
                                next_state <= M_IDLE;
                        end
                        M_ADDR:
                        begin
                            sda_oe     <= 1'b1;
                            ptr[7:0]   <= shreg;
                            next_state <= M_WRITE;
                        end
                        M_WRITE:
                        begin
                            sda_oe      <= 1'b1;
                            mem[ptr]    <= shreg; // write cycle done at once
                            write_count <= write_count + 1;
                        end
                        default:
                            ptr <= ptr + 11'd1;
                    endcase
                end
                else if (bit_cnt == 4'd9)
                begin
                    state   <= next_state;
                    bit_cnt <= '0;
                    sda_oe  <= (next_state == M_READ) ? !mem[ptr][7] : 1'b0;
                    shreg   <= {mem[ptr][6:0], 1'b0};
                end
                else if (state == M_READ && bit_cnt != 4'd0)
                begin
                    sda_oe <= !shreg[7];
                    shreg  <= {shreg[6:0], 1'b0};
                end
            end
        end
    end

endmodule : eeprom_model

`default_nettype wire

// File: dv/tb_eeprom_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_host
    import i2c_pkg::*;
    import apb_regs_pkg::*;
();

    localparam int CLK_DIV     = 4;
    localparam int N_RAND      = 20;
    localparam int N_XFERS     = 2 * N_RAND + 9;    // random pairs plus the directed tests
    localparam int BIT_CYCLES  = 4 * CLK_DIV;
    localparam int XFER_CYCLES = 40 * BIT_CYCLES;   // a random read needs 39 bit times
    localparam int WATCHDOG_NS = 2 * N_XFERS * XFER_CYCLES * 40;
    localparam int POLL_LIMIT  = XFER_CYCLES;

    logic      CLK;
    logic      RESET;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      scl;
    logic      dut_sda_oe;
    logic      model_sda_oe;
    logic      sda_bus;
    logic      nack_en;
    int        write_count;
    byte_t     ref_mem [0:2047];
    ee_addr_t  rand_addr [N_RAND];
    integer    seed;

    assign sda_bus = !(dut_sda_oe || model_sda_oe); // open drain wired-AND

    eeprom_host #(
        .CLK_DIV (CLK_DIV)
    ) dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_oe  (dut_sda_oe),
        .sda_in  (sda_bus)
    );

    eeprom_model model0
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda_bus),
        .nack_en     (nack_en),
        .sda_oe      (model_sda_oe),
        .write_count (write_count)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check_value(input string name, input apb_data_t expected,
                               input apb_data_t actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first failed check");
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK); // access cycle
        data = prdata;
        err  = pslverr;
        check_value("pready", 32'd1, 32'(pready));
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle(output apb_data_t status);
        logic err;
        int   polls;
        polls = 0;
        do
        begin
            apb_read(REG_STATUS, status, err);
            polls++;
            assert (polls < POLL_LIMIT)
            else
            begin
                $display("busy still set after %0d status polls", polls);
                $display("*** TEST FAILED ***");
                $fatal(1, "transfer did not finish");
            end
        end
        while (status[STAT_BUSY_BIT]);
    endtask

    task automatic eeprom_write(input ee_addr_t addr, input byte_t data,
                                output apb_data_t status);
        apb_write(REG_ADDR, 32'(addr));
        apb_write(REG_WDATA, 32'(data));
        apb_write(REG_CMD, 32'h1); // go
        wait_idle(status);
    endtask

    task automatic eeprom_read(input ee_addr_t addr, output byte_t data,
                               output apb_data_t status);
        apb_data_t word;
        logic      err;
        apb_write(REG_ADDR, 32'(addr));
        apb_write(REG_CMD, 32'h3); // go and read
        wait_idle(status);
        apb_read(REG_RDATA, word, err);
        data = word[7:0];
    endtask

    task automatic write_checked(input string name, input ee_addr_t addr, input byte_t data);
        apb_data_t status;
        eeprom_write(addr, data, status);
        ref_mem[addr] = data;
        check_value($sformatf("%s 0x%03h nack", name, addr), 32'd0,
                    32'(status[STAT_NACK_BIT]));
    endtask

    task automatic read_checked(input string name, input ee_addr_t addr);
        apb_data_t status;
        byte_t     data;
        eeprom_read(addr, data, status);
        check_value($sformatf("%s 0x%03h nack", name, addr), 32'd0,
                    32'(status[STAT_NACK_BIT]));
        check_value($sformatf("%s 0x%03h", name, addr), 32'(ref_mem[addr]), 32'(data));
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        apb_data_t word;
        apb_data_t status;
        logic      err;
        int        writes_before;

        seed    = 32'h9134_5abe;
        RESET   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        nack_en = 1'b0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;

        @(negedge CLK);
        check_value("reset scl", 32'd1, 32'(scl));
        check_value("reset sda_oe", 32'd0, 32'(dut_sda_oe));
        apb_read(REG_STATUS, word, err);
        check_value("reset status", 32'd0, word);

        for (int i = 0; i < N_RAND; i++)
        begin
            rand_addr[i] = ee_addr_t'($random(seed));
            write_checked("random write", rand_addr[i], byte_t'($random(seed)));
        end
        for (int i = N_RAND - 1; i >= 0; i--)
            read_checked("random read", rand_addr[i]); // reverse order

        // same low byte in two blocks
        write_checked("block write", 11'h0FF, 8'hA5);
        write_checked("block write", 11'h1FF, 8'h5A);
        read_checked("block read", 11'h0FF);
        read_checked("block read", 11'h1FF);

        @(posedge CLK);
        nack_en <= 1'b1;
        eeprom_write(11'h0FF, 8'h3C, status);
        check_value("nack abort flag", 32'd1, 32'(status[STAT_NACK_BIT]));
        @(posedge CLK);
        nack_en <= 1'b0;
        read_checked("after nack", 11'h0FF);

        writes_before = write_count;
        apb_write(REG_ADDR, 32'h2AB);
        apb_write(REG_WDATA, 32'h3C);
        apb_write(REG_CMD, 32'h1);
        apb_read(REG_STATUS, status, err);
        check_value("busy after go", 32'd1, 32'(status[STAT_BUSY_BIT]));
        apb_write(REG_ADDR, 32'h1FF);
        apb_write(REG_WDATA, 32'hC3);
        apb_write(REG_CMD, 32'h1); // dropped while busy
        wait_idle(status);
        ref_mem[11'h2AB] = 8'h3C;
        read_checked("go while busy", 11'h1FF);
        read_checked("go while busy", 11'h2AB);
        check_value("writes during busy go", 32'd1, 32'(write_count - writes_before));

        apb_write(REG_ADDR, 32'h5A3);
        apb_read(REG_ADDR, word, err);
        check_value("addr readback", 32'h5A3, word);
        check_value("addr pslverr", 32'd0, 32'(err));
        apb_write(REG_WDATA, 32'h7E);
        apb_read(REG_WDATA, word, err);
        check_value("wdata readback", 32'h7E, word);
        apb_read(5'h14, word, err);
        check_value("unmapped pslverr", 32'd1, 32'(err));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_eeprom_host

`default_nettype wire

// File: eeprom_ctrl/eeprom_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq
    import i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     start,
    input  wire logic     rnw,
    input  wire ee_addr_t ee_addr,
    input  wire byte_t    wdata,
    output logic          done,
    output logic          nack,
    output byte_t         rdata,
    output logic          cmd_valid,
    output bit_cmd_t      cmd,
    output byte_t         tx_byte,
    output logic          tx_ack,
    input  wire logic     cmd_ready,
    input  wire logic     cmd_done,
    input  wire byte_t    rx_byte,
    input  wire logic     rx_ack
);

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_DEV_WR,
        ST_ADDR,
        ST_WDATA,
        ST_RESTART,
        ST_DEV_RD,
        ST_RDATA,
        ST_STOP,
        ST_DONE
    } seq_state_t;

    seq_state_t state;
    logic       pending;    // command handed to the bit engine, waiting for cmd_done
    logic       slave_nack;
    ee_addr_t   addr_q;
    byte_t      wdata_q;
    logic       rnw_q;

    assign done       = (state == ST_DONE);
    assign cmd_valid  = (state != ST_IDLE) && (state != ST_DONE) && !pending;
    assign slave_nack = (cmd == WRITE_BYTE) && rx_ack;

    always_comb
    begin
        cmd     = WRITE_BYTE;
        tx_byte = '0;
        tx_ack  = 1'b1; // single byte read, so it is always the last one
        case (state)
            ST_START, ST_RESTART: cmd = START;
            ST_DEV_WR:            tx_byte = {DEV_CODE, addr_q[10:8], 1'b0};
            ST_ADDR:              tx_byte = addr_q[7:0];
            ST_WDATA:             tx_byte = wdata_q;
            ST_DEV_RD:            tx_byte = {DEV_CODE, addr_q[10:8], 1'b1};
            ST_RDATA:             cmd = READ_BYTE;
            ST_STOP:              cmd = STOP;
            default:              cmd = WRITE_BYTE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            pending <= 1'b0;
            nack    <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                pending <= 1'b1;

            if (state == ST_IDLE)
            begin
                if (start)
                begin
                    state <= ST_START;
                    nack  <= 1'b0;
                end
            end
            else if (state == ST_DONE)
                state <= ST_IDLE;
            else if (cmd_done)
            begin
                pending <= 1'b0;
                if (slave_nack)
                    nack <= 1'b1;
                case (state)
                    ST_START:   state <= ST_DEV_WR;
                    ST_DEV_WR:  state <= slave_nack ? ST_STOP : ST_ADDR;
                    ST_ADDR:    state <= slave_nack ? ST_STOP : (rnw_q ? ST_RESTART : ST_WDATA);
                    ST_WDATA:   state <= ST_STOP;
                    ST_RESTART: state <= ST_DEV_RD;
                    ST_DEV_RD:  state <= slave_nack ? ST_STOP : ST_RDATA;
                    ST_RDATA:   state <= ST_STOP;
                    ST_STOP:    state <= ST_DONE;
                    default:    state <= ST_IDLE;
                endcase
            end
        end
    end

    // request fields held for the whole transfer
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            addr_q  <= ee_addr;
            wdata_q <= wdata;
            rnw_q   <= rnw;
        end
        if (state == ST_RDATA && cmd_done)
            rdata <= rx_byte;
    end

endmodule : eeprom_seq

`default_nettype wire

// File: eeprom_ctrl/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     cmd_valid,
    input  wire bit_cmd_t cmd,
    input  wire byte_t    tx_byte,
    input  wire logic     tx_ack,
    output logic          cmd_ready,
    output logic          cmd_done,
    output byte_t         rx_byte,
    output logic          rx_ack,
    output logic          scl,
    output logic          sda_oe,
    input  wire logic     sda_in
);

    localparam int            QW     = $clog2(CLK_DIV + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    typedef enum logic [2:0]
    {
        E_IDLE,
        E_START,
        E_STOP,
        E_WRITE,
        E_READ
    } eng_state_t;

    eng_state_t    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    quarter;
    logic [3:0]    bit_cnt;   // 0..7 data, 8 ack
    byte_t         tx_sh;
    byte_t         rx_sh;
    logic          ack_out;
    logic          scl_last;
    logic          sda_last;
    logic          q_end;
    logic          bit_end;
    logic          last_bit;

    assign q_end     = (qcnt == Q_LAST);
    assign bit_end   = q_end && (quarter == 2'd3);
    assign last_bit  = (state == E_START) || (state == E_STOP) || (bit_cnt == 4'd8);
    assign cmd_ready = (state == E_IDLE);
    assign cmd_done  = (state != E_IDLE) && bit_end && last_bit;
    assign rx_byte   = rx_sh;

    // SCL high in quarters 1 and 2; SDA only moves in quarter 0 unless START/STOP
    always_comb
    begin
        scl    = scl_last;  // hold bus between commands
        sda_oe = sda_last;
        case (state)
            E_START:
            begin
                scl    = (quarter == 2'd1) || (quarter == 2'd2);
                sda_oe = quarter[1];  // falls while scl high
            end
            E_STOP:
            begin
                scl    = (quarter != 2'd0);
                sda_oe = !quarter[1]; // released while scl high
            end
            E_WRITE:
            begin
                scl    = (quarter == 2'd1) || (quarter == 2'd2);
                sda_oe = (bit_cnt == 4'd8) ? 1'b0 : !tx_sh[7];
            end
            E_READ:
            begin
                scl    = (quarter == 2'd1) || (quarter == 2'd2);
                sda_oe = (bit_cnt == 4'd8) ? !ack_out : 1'b0;
            end
            default:
            begin
                scl    = scl_last;
                sda_oe = sda_last;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= E_IDLE;
            qcnt     <= '0;
            quarter  <= '0;
            bit_cnt  <= '0;
            scl_last <= 1'b1;
            sda_last <= 1'b0;
        end
        else
        begin
            scl_last <= scl;
            sda_last <= sda_oe;
            if (state == E_IDLE)
            begin
                qcnt    <= '0;
                quarter <= '0;
                bit_cnt <= '0;
                if (cmd_valid)
                begin
                    case (cmd)
                        START:      state <= E_START;
                        STOP:       state <= E_STOP;
                        WRITE_BYTE: state <= E_WRITE;
                        default:    state <= E_READ;
                    endcase
                end
            end
            else
            begin
                qcnt <= q_end ? '0 : qcnt + 1'b1;
                if (q_end)
                    quarter <= quarter + 2'd1;
                if (bit_end)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (last_bit)
                        state <= E_IDLE;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            tx_sh   <= tx_byte;
            ack_out <= tx_ack;
        end
        else if (bit_end)
            tx_sh <= {tx_sh[6:0], 1'b0}; // msb first

        // sample at the end of the third quarter
        if (q_end && quarter == 2'd2 && (state == E_WRITE || state == E_READ))
        begin
            if (bit_cnt == 4'd8)
                rx_ack <= sda_in;
            else
                rx_sh <= {rx_sh[6:0], sda_in};
        end
    end

endmodule : i2c_bit_engine

`default_nettype wire

// File: eeprom_host.f
common/i2c_pkg.sv
common/apb_regs_pkg.sv
eeprom_ctrl/eeprom_seq.sv
eeprom_ctrl/i2c_bit_engine.sv
hdl/apb_eeprom_regs.sv
hdl/eeprom_host.sv
dv/eeprom_model.sv
dv/tb_eeprom_host.sv

// File: hdl/apb_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_eeprom_regs
    import i2c_pkg::*;
    import apb_regs_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           start,
    output logic           rnw,
    output ee_addr_t       ee_addr,
    output byte_t          wdata,
    input  wire logic      done,
    input  wire logic      nack,
    input  wire byte_t     rdata
);

    logic  busy_r;
    logic  busy;
    logic  nack_r;
    logic  nack_flag;
    byte_t rdata_r;
    logic  wr_en;
    logic  go;
    logic  mapped;

    assign wr_en     = psel && penable && pwrite;
    assign go        = wr_en && (paddr == REG_CMD) && pwdata[CMD_GO_BIT] && !busy;
    assign busy      = busy_r && !done;     // drops with done
    assign nack_flag = done ? nack : nack_r;
    assign pready    = 1'b1;
    assign mapped    = (paddr == REG_CMD) || (paddr == REG_ADDR) || (paddr == REG_WDATA)
                    || (paddr == REG_STATUS) || (paddr == REG_RDATA);
    assign pslverr   = psel && penable && !mapped;

    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_CMD:    prdata[CMD_RNW_BIT] = rnw;
            REG_ADDR:   prdata[10:0] = ee_addr;
            REG_WDATA:  prdata[7:0] = wdata;
            REG_STATUS:
            begin
                prdata[STAT_BUSY_BIT] = busy;
                prdata[STAT_NACK_BIT] = nack_flag;
            end
            REG_RDATA:  prdata[7:0] = rdata_r;
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start  <= 1'b0;
            busy_r <= 1'b0;
            nack_r <= 1'b0;
            rnw    <= 1'b0;
        end
        else
        begin
            start <= go;
            if (go)
            begin
                busy_r <= 1'b1;
                nack_r <= 1'b0;
                rnw    <= pwdata[CMD_RNW_BIT];
            end
            else if (done)
            begin
                busy_r <= 1'b0;
                nack_r <= nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_en && paddr == REG_ADDR)
            ee_addr <= pwdata[10:0];
        if (wr_en && paddr == REG_WDATA)
            wdata <= pwdata[7:0];
        if (done)
            rdata_r <= rdata;
    end

endmodule : apb_eeprom_regs

`default_nettype wire

// File: hdl/eeprom_host.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_host
    import i2c_pkg::*;
    import apb_regs_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           scl,      // high = released
    output logic           sda_oe,   // high pulls SDA low
    input  wire logic      sda_in
);

    logic     start;
    logic     rnw;
    ee_addr_t ee_addr;
    byte_t    wdata;
    logic     done;
    logic     nack;
    byte_t    rdata;
    logic     cmd_valid;
    bit_cmd_t cmd;
    byte_t    tx_byte;
    logic     tx_ack;
    logic     cmd_ready;
    logic     cmd_done;
    byte_t    rx_byte;
    logic     rx_ack;

    apb_eeprom_regs u_regs
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .rnw     (rnw),
        .ee_addr (ee_addr),
        .wdata   (wdata),
        .done    (done),
        .nack    (nack),
        .rdata   (rdata)
    );

    eeprom_seq u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .rnw       (rnw),
        .ee_addr   (ee_addr),
        .wdata     (wdata),
        .done      (done),
        .nack      (nack),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule : eeprom_host

`default_nettype wire
